/* sources.f */
+incdir+common
common/rvIsaPkg.sv
common/pipePkg.sv
verilog/fetchUnit.sv
decode/instrDecoder.sv
decode/regFile.sv
decode/decodeExecuteReg.sv
execute/executeUnit.sv
verilog/pipelineControl.sv
verilog/rvCoreTop.sv
dv/tbClockGen.sv
dv/rvCoreTb.sv

/* Makefile */
# Verilator build and run for the RV32I core testbench.

VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "\*\* PASS \*\*" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/rvCoreTb.sv */
`include "coreConsts.svh"

module rvCoreTb import pipePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Timeout = 4000;          // cycles allowed for any single wait.
    localparam int MemWords = 256;

    logic clk, rst, softRst, dutRst, retireValid, halted, illegal;
    wbMaster_t  ibus;
    wbSlave_t   ibusResp;
    retireRec_t retire;
    word_t      progMem [MemWords];
    word_t      refRegs [`CORE_NUM_REGS];
    addr_t      refPc;
    logic       refStop, refIllegal;
    int         emitIdx, waitLeft;
    int         seed = 32'h03e7_3be9;

    assign dutRst = rst || softRst;

    tbClockGen i_clockGen (.clk, .rst);

    rvCoreTop i_dut (
        .clk, .rst(dutRst), .ibus, .ibusResp, .retireValid, .retire, .halted, .illegal
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stopRun();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string msg);
        $display("error at %0t: %s", $time, msg);
        stopRun();
    endtask

    task automatic reportTimeout(input string what);
        $display("timed out while waiting for %s", what);
        stopRun();
    endtask

    task automatic checkRetire(input retireRec_t got, input retireRec_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("retire pc %h rd %0d value %h, expected pc %h rd %0d value %h",
                got.pc, got.rd, got.value, exp.pc, exp.rd, exp.value));
        end
    endtask

    task automatic checkAddr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("bus address %h, expected %h", got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %b, expected %b", name, got, exp));
        end
    endtask

    task automatic checkStatus(input logic expHalted, input logic expIllegal);
        checkFlag("halted", halted, expHalted);
        checkFlag("illegal", illegal, expIllegal);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of the instruction subset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic word_t aluRef(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one instruction of the model, a terminator only sets refStop.
    function automatic retireRec_t refStep();
        word_t      ins, a, b, res, immI, immB, immJ;
        logic [2:0] f3;
        regIdx_t    rd;
        logic       wr, take;
        addr_t      nextPc;
        retireRec_t rec;
        ins  = progMem[refPc[9:2]];
        f3   = ins[14:12];
        rd   = ins[11:7];
        a    = refRegs[ins[19:15]];
        b    = refRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = refPc + 4;
        wr   = 1'b1;
        take = 1'b0;
        res  = '0;
        case (ins[6:0])
            7'h37: res = {ins[31:12], 12'd0};
            7'h17: res = refPc + {ins[31:12], 12'd0};
            7'h6f: begin
                res    = refPc + 4;
                nextPc = refPc + immJ;
            end
            7'h67: begin
                res    = refPc + 4;
                nextPc = (a + immI) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    take = a == b;
                    3'd1:    take = a != b;
                    3'd4:    take = $signed(a) < $signed(b);
                    3'd5:    take = $signed(a) >= $signed(b);
                    3'd6:    take = a < b;
                    default: take = a >= b;
                endcase
                if (take) nextPc = refPc + immB;
            end
            7'h13: res = aluRef(f3, f3 == 3'd5 && ins[30], a, immI);
            7'h33: res = aluRef(f3, ins[30], a, b);
            default: begin
                refStop    = 1'b1;
                refIllegal = ins != 32'h0010_0073; // anything but ebreak.
                return '0;
            end
        endcase
        rec.pc    = refPc;
        rec.rd    = wr ? rd : '0;
        rec.value = (rec.rd == '0) ? '0 : res;
        if (rec.rd != '0) refRegs[rec.rd] = res;
        refPc = nextPc;
        return rec;
    endfunction

    task automatic resetModel();
        for (int i = 0; i < `CORE_NUM_REGS; i++) refRegs[i] = '0;
        refPc      = `CORE_RESET_PC;
        refStop    = 1'b0;
        refIllegal = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic clearProgram();
        for (int i = 0; i < MemWords; i++) begin
            progMem[i] = 32'(i * 4) << 7;   // opcode zero, so a stray fetch is illegal.
        end
        emitIdx = 0;
    endtask

    task automatic emit(input word_t w);
        progMem[emitIdx] = w;
        emitIdx++;
    endtask

    function automatic word_t encR(input int f7, input int rs2, input int rs1,
                                   input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction

    function automatic word_t encI(input int imm, input int rs1, input int f3,
                                   input int rd, input int op);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
    endfunction

    function automatic word_t encB(input int off, input int rs2, input int rs1, input int f3);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'h63};
    endfunction

    function automatic word_t encJ(input int off, input int rd);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic loadMainProgram();
        int f3s [6]  = '{0, 1, 4, 5, 6, 7};
        int tkA [6]  = '{1, 1, 2, 1, 1, 2};
        int tkB [6]  = '{1, 2, 1, 2, 2, 1};
        int ntA [6]  = '{1, 1, 1, 2, 2, 1};
        int ntB [6]  = '{2, 1, 2, 1, 1, 2};
        clearProgram();
        emit(encI(5, 0, 0, 1, 'h13));       // x1 = 5
        emit(encI(-12, 1, 0, 2, 'h13));     // x2 = -7, depends on the line above
        for (int f = 0; f < 8; f++) emit(encR(0, 2, 1, f, 3 + f));
        emit(encR('h20, 2, 1, 0, 11));      // sub
        emit(encR('h20, 1, 2, 5, 12));      // sra
        emit(encI(3, 2, 1, 13, 'h13));
        emit(encI('h401, 2, 5, 14, 'h13));
        emit(encI(28, 2, 5, 15, 'h13));
        emit(encI(-1, 1, 3, 16, 'h13));
        emit(encI(-3, 2, 2, 17, 'h13));
        emit(encI('h7f0, 3, 4, 18, 'h13));
        emit(encI('h0f0, 3, 6, 18, 'h13));
        emit(encI('h0ff, 18, 7, 18, 'h13));
        emit({20'habcde, 5'd14, 7'h37});    // lui
        emit({20'h12345, 5'd15, 7'h17});    // auipc
        emit(encI(7, 1, 0, 0, 'h13));       // write to x0
        emit(encR(0, 0, 1, 0, 19));
        for (int i = 0; i < 6; i++) begin
            emit(encB(8, ntB[i], ntA[i], f3s[i]));
            emit(encI(1, 19, 0, 19, 'h13));
            emit(encB(8, tkB[i], tkA[i], f3s[i]));
            emit(encI(99, 0, 0, 25, 'h13)); // squashed by the taken branch
        end
        emit(encJ(8, 21));
        emit(encI(99, 0, 0, 25, 'h13));
        emit({20'h0, 5'd22, 7'h17});        // auipc x22, 0
        emit(encI(13, 22, 0, 23, 'h67));   // jalr lands two words on, bit 0 cleared
        emit(encI(99, 0, 0, 25, 'h13));
        emit(encI(1, 21, 0, 24, 'h13));
        emit(32'h0010_0073);                // ebreak
        emit(encI(99, 0, 0, 25, 'h13));
    endtask

    task automatic loadIllegalProgram();
        clearProgram();
        emit(encI(3, 0, 0, 1, 'h13));
        emit(encR(0, 1, 1, 0, 2));
        emit(32'h0000_2083);                // lw, outside the subset
        emit(encI(99, 0, 0, 25, 'h13));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone slave and retire monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        ibusResp = '0;
        waitLeft = -1;
        forever begin
            @(negedge clk);
            if (dutRst || ibusResp.ack || !(ibus.cyc && ibus.stb)) begin
                ibusResp.ack = 1'b0;
                waitLeft     = -1;
            end else begin
                if (waitLeft < 0) waitLeft = int'($unsigned($random(seed)) % 4);
                if (waitLeft == 0) begin
                    ibusResp.ack = 1'b1;
                    ibusResp.dat = progMem[ibus.adr[9:2]];
                end
                waitLeft--;
            end
        end
    end

    always @(negedge clk) begin
        retireRec_t exp;
        if (!dutRst && retireValid) begin
            exp = refStep();
            if (refStop) reportMismatch("retire seen after the end of the program");
            checkRetire(retire, exp);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scenarios
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic waitResetDone();
        int n;
        for (n = 0; n < Timeout && dutRst; n++) @(negedge clk);
        if (dutRst) reportTimeout("reset release");
    endtask

    task automatic waitFirstFetch();
        int n;
        for (n = 0; n < Timeout && !ibus.cyc; n++) @(negedge clk);
        if (!ibus.cyc) reportTimeout("the first bus cycle");
        checkAddr(ibus.adr, `CORE_RESET_PC);
    endtask

    task automatic runToHalt(input logic expIllegal);
        int n;
        for (n = 0; n < Timeout && !halted; n++) @(negedge clk);
        if (!halted) reportTimeout("halted");
        @(negedge clk);
        void'(refStep());                   // the model must now sit on the terminator.
        if (!refStop) reportMismatch("core halted before the end of the program");
        checkStatus(1'b1, expIllegal);
        checkFlag("illegal as predicted", illegal, refIllegal);
        repeat (8) begin
            @(negedge clk);
            checkFlag("cyc after halt", ibus.cyc, 1'b0);
            checkFlag("stb after halt", ibus.stb, 1'b0);
        end
    endtask

    initial begin
        softRst = 1'b0;
        resetModel();
        loadMainProgram();
        @(posedge clk);
        @(negedge clk);
        checkFlag("cyc in reset", ibus.cyc, 1'b0);
        checkFlag("stb in reset", ibus.stb, 1'b0);
        checkFlag("retireValid in reset", retireValid, 1'b0);
        checkStatus(1'b0, 1'b0);
        waitResetDone();
        waitFirstFetch();
        runToHalt(1'b0);

        softRst = 1'b1;
        loadIllegalProgram();
        resetModel();
        repeat (4) @(negedge clk);
        softRst = 1'b0;
        waitFirstFetch();
        runToHalt(1'b1);

        $display("** PASS **");
        $finish;
    end

endmodule

/* dv/tbClockGen.sv */
module tbClockGen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime HalfPeriod = 50ns;  // 100 ns clock period.

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    // reset covers four rising edges and is released on a falling edge.
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* verilog/rvCoreTop.sv */
module rvCoreTop import pipePkg::*; (
    input  logic       clk,
    input  logic       rst,
    output wbMaster_t  ibus,
    input  wbSlave_t   ibusResp,
    output logic       retireValid,
    output retireRec_t retire,
    output logic       halted,
    output logic       illegal
);

    fetchPacket_t  fetched;
    ctrlFields_t   decCtrl;
    word_t         decImm;
    regIdx_t       rs1Idx, rs2Idx, rdIdx;
    word_t         rs1Val, rs2Val;
    logic          haltReq, illegalReq;
    decodeBundle_t decBundle, exeBundle;
    logic          redirectTaken;
    addr_t         redirectTarget;
    logic          wrEn;
    regIdx_t       wrIdx;
    word_t         wrData;
    logic          flush, fetchEnable;

    fetchUnit i_fetchUnit (
        .clk, .rst, .fetchEnable, .flush, .redirectTarget,
        .bus(ibus), .busResp(ibusResp), .fetched
    );

    instrDecoder i_instrDecoder (
        .fetched, .ctrl(decCtrl), .imm(decImm),
        .rs1Idx, .rs2Idx, .rdIdx, .haltReq, .illegalReq
    );

    regFile i_regFile (
        .clk, .rst, .rs1Idx, .rs2Idx, .rs1Val, .rs2Val, .wrEn, .wrIdx, .wrData
    );

    assign decBundle = '{valid: fetched.valid, ctrl: decCtrl, rs1Val: rs1Val,
                         rs2Val: rs2Val, pc: fetched.pc, rd: rdIdx, imm: decImm,
                         pcPlus4: fetched.pc + addr_t'(4)};

    decodeExecuteReg i_decodeExecuteReg (
        .clk, .rst, .clr(flush), .bundleIn(decBundle), .bundleOut(exeBundle)
    );

    executeUnit i_executeUnit (
        .clk, .rst, .bundle(exeBundle), .redirectTaken, .redirectTarget,
        .wrEn, .wrIdx, .wrData, .retireValid, .retire
    );

    pipelineControl i_pipelineControl (
        .clk, .rst, .redirectTaken, .haltReq, .illegalReq,
        .execValid(exeBundle.valid), .flush, .fetchEnable, .halted, .illegal
    );

endmodule

/* verilog/pipelineControl.sv */
module pipelineControl (
    input  logic clk,
    input  logic rst,
    input  logic redirectTaken,
    input  logic haltReq,
    input  logic illegalReq,
    input  logic execValid,
    output logic flush,
    output logic fetchEnable,
    output logic halted,
    output logic illegal
);

    typedef enum logic [1:0] {RUN, DRAIN, HALTED} ctrlState_e;

    ctrlState_e state;
    logic       stopReq;
    logic       illegalPending;

    // a redirect squashes the instruction in decode, so its request does not count.
    assign stopReq     = (haltReq || illegalReq) && !redirectTaken;
    assign flush       = redirectTaken || (state == RUN && stopReq);
    assign fetchEnable = state == RUN && !stopReq;
    assign halted      = state == HALTED;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= RUN;
            illegalPending <= 1'b0;
            illegal        <= 1'b0;
        end else begin
            case (state)
                RUN: if (stopReq) begin
                    state          <= DRAIN;
                    illegalPending <= illegalReq;
                end
                DRAIN: if (!execValid) begin
                    state   <= HALTED;
                    illegal <= illegalPending;
                end
                default: state <= HALTED; // only reset leaves here.
            endcase
        end
    end

endmodule

/* execute/executeUnit.sv */
module executeUnit import rvIsaPkg::*, pipePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  decodeBundle_t bundle,
    output logic          redirectTaken,
    output addr_t         redirectTarget,
    output logic          wrEn,
    output regIdx_t       wrIdx,
    output word_t         wrData,
    output logic          retireValid,
    output retireRec_t    retire
);

    word_t opA;
    word_t opB;
    word_t aluResult;
    word_t result;
    logic  branchTaken;

    assign opA = bundle.rs1Val;
    assign opB = bundle.ctrl.aluSrcImm ? bundle.imm : bundle.rs2Val;

    always_comb begin
        case (bundle.ctrl.aluOp)
            ALU_ADD:   aluResult = opA + opB;
            ALU_SUB:   aluResult = opA - opB;
            ALU_SLL:   aluResult = opA << opB[4:0];
            ALU_SLT:   aluResult = word_t'($signed(opA) < $signed(opB));
            ALU_SLTU:  aluResult = word_t'(opA < opB);
            ALU_XOR:   aluResult = opA ^ opB;
            ALU_SRL:   aluResult = opA >> opB[4:0];
            ALU_SRA:   aluResult = word_t'($signed(opA) >>> opB[4:0]);
            ALU_OR:    aluResult = opA | opB;
            ALU_AND:   aluResult = opA & opB;
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    always_comb begin
        case (bundle.ctrl.branch)
            BR_EQ:   branchTaken = bundle.rs1Val == bundle.rs2Val;
            BR_NE:   branchTaken = bundle.rs1Val != bundle.rs2Val;
            BR_LT:   branchTaken = $signed(bundle.rs1Val) < $signed(bundle.rs2Val);
            BR_GE:   branchTaken = $signed(bundle.rs1Val) >= $signed(bundle.rs2Val);
            BR_LTU:  branchTaken = bundle.rs1Val < bundle.rs2Val;
            BR_GEU:  branchTaken = bundle.rs1Val >= bundle.rs2Val;
            default: branchTaken = 1'b0;
        endcase
    end

    assign redirectTaken  = bundle.valid && (bundle.ctrl.jump != JUMP_NONE || branchTaken);
    assign redirectTarget = (bundle.ctrl.jump == JUMP_JALR) ?
                            (bundle.rs1Val + bundle.imm) & ~addr_t'(1) :
                            bundle.pc + bundle.imm;
    assign result = (bundle.ctrl.resultSrc == RES_PCPLUS4) ? bundle.pcPlus4 : aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrEn        <= 1'b0;
            retireValid <= 1'b0;
        end else begin
            wrEn        <= bundle.valid && bundle.ctrl.regWrite;
            retireValid <= bundle.valid;
        end
    end

    always_ff @(posedge clk) begin
        wrIdx        <= bundle.rd;
        wrData       <= result;
        retire.pc    <= bundle.pc;
        retire.rd    <= bundle.rd;
        retire.value <= (bundle.rd == '0) ? '0 : result; // x0 reads back as zero.
    end

    // each instruction leaves decodeExecuteReg once, so it retires once.
    assert property (@(posedge clk) disable iff (rst)
        retireValid |=> !(retireValid && retire.pc == $past(retire.pc)));

endmodule

/* decode/decodeExecuteReg.sv */
module decodeExecuteReg import pipePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          clr,
    input  decodeBundle_t bundleIn,
    output decodeBundle_t bundleOut
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode to execute boundary
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            bundleOut <= '0;                // an all-zero bundle is a bubble.
        end else begin
            bundleOut <= bundleIn;
        end
    end

    // decode only enables a write for a valid packet, so a bubble never writes.
    assert property (@(posedge clk) disable iff (rst)
        !bundleOut.valid |-> !bundleOut.ctrl.regWrite);

endmodule

/* decode/regFile.sv */
`include "coreConsts.svh"

module regFile import pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regIdx_t rs1Idx,
    input  regIdx_t rs2Idx,
    output word_t   rs1Val,
    output word_t   rs2Val,
    input  logic    wrEn,
    input  regIdx_t wrIdx,
    input  word_t   wrData
);

    word_t regs [`CORE_NUM_REGS];

    function automatic word_t readPort(input regIdx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wrEn && wrIdx == idx) begin
            val = wrData;                   // write-through for the value retiring now.
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1Val = readPort(rs1Idx);
        rs2Val = readPort(rs2Idx);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

/* decode/instrDecoder.sv */
module instrDecoder import rvIsaPkg::*, pipePkg::*; (
    input  fetchPacket_t fetched,
    output ctrlFields_t  ctrl,
    output word_t        imm,
    output regIdx_t      rs1Idx,
    output regIdx_t      rs2Idx,
    output regIdx_t      rdIdx,
    output logic         haltReq,
    output logic         illegalReq
);

    word_t       instr;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       immI, immB, immU, immJ;
    ctrlFields_t dec;
    logic        legal;
    logic        isEbreak;

    function automatic aluOp_e aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic branchCond_e branchFromFunct3(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;        // 010 and 011 are not branches.
        endcase
    endfunction

    assign instr  = fetched.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec      = '0;
        imm      = immI;
        legal    = 1'b1;
        isEbreak = 1'b0;
        case (opcode)
            OP_OP: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = aluFromFunct3(funct3, funct7[5]);
                legal        = funct7 == 7'b0000000 ||
                               (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OP_IMM: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluOp     = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) begin
                    legal = funct7 == 7'b0000000;
                end else if (funct3 == 3'b101) begin
                    legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                end
            end
            OP_LUI, OP_AUIPC: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluOp     = ALU_PASSB;
                imm           = (opcode == OP_AUIPC) ? fetched.pc + immU : immU; // pc is folded in here.
            end
            OP_JAL: begin
                dec.regWrite  = 1'b1;
                dec.jump      = JUMP_JAL;
                dec.resultSrc = RES_PCPLUS4;
                imm           = immJ;
            end
            OP_JALR: begin
                dec.regWrite  = 1'b1;
                dec.jump      = JUMP_JALR;
                dec.resultSrc = RES_PCPLUS4;
                legal         = funct3 == 3'b000;
            end
            OP_BRANCH: begin
                dec.branch = branchFromFunct3(funct3);
                imm        = immB;
                legal      = dec.branch != BR_NONE;
            end
            OP_SYSTEM: begin
                isEbreak = instr[31:20] == 12'h001 && instr[19:7] == '0;
                legal    = isEbreak;            // ecall and csr access are outside the subset.
            end
            default: legal = 1'b0;
        endcase
    end

    assign ctrl       = (fetched.valid && legal) ? dec : '0;
    assign rs1Idx     = instr[19:15];
    assign rs2Idx     = instr[24:20];
    assign rdIdx      = dec.regWrite ? instr[11:7] : '0; // non-writing ops retire with rd zero.
    assign haltReq    = fetched.valid && isEbreak;
    assign illegalReq = fetched.valid && !legal;

endmodule

/* verilog/fetchUnit.sv */
`include "coreConsts.svh"

module fetchUnit import pipePkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         fetchEnable,
    input  logic         flush,
    input  addr_t        redirectTarget,
    output wbMaster_t    bus,
    input  wbSlave_t     busResp,
    output fetchPacket_t fetched
);

    addr_t pc;                              // address of the next fetch.
    addr_t nextPc;
    logic  discard;
    logic  ackSeen;
    logic  startFetch;

    assign ackSeen    = bus.cyc && busResp.ack;
    assign nextPc     = flush ? redirectTarget : pc;
    assign startFetch = !bus.cyc && fetchEnable; // cyc stays low for a cycle after each ack.

    always_ff @(posedge clk) begin
        if (rst) begin
            pc            <= `CORE_RESET_PC;
            bus           <= '0;
            discard       <= 1'b0;
            fetched.valid <= 1'b0;
        end else begin
            fetched.valid <= 1'b0;          // decode consumes the packet in one cycle.
            if (ackSeen) begin
                bus.cyc <= 1'b0;
                bus.stb <= 1'b0;
                discard <= 1'b0;
                if (!discard && !flush) begin
                    fetched.valid <= 1'b1;
                    fetched.pc    <= bus.adr;
                    fetched.instr <= busResp.dat;
                end
            end else if (bus.cyc && flush) begin
                discard <= 1'b1;            // the cycle in flight belongs to the old path.
            end
            if (startFetch) begin
                bus.cyc <= 1'b1;
                bus.stb <= 1'b1;
                bus.adr <= nextPc;
                pc      <= nextPc + addr_t'(4);
            end else if (flush) begin
                pc <= redirectTarget;
            end
        end
    end

    // cyc and stb drop together for at least one cycle after each ack.
    assert property (@(posedge clk) disable iff (rst)
        bus.cyc && busResp.ack |=> !bus.cyc && !bus.stb);

    // a waiting request must keep its address until the slave answers.
    assert property (@(posedge clk) disable iff (rst)
        bus.cyc && !busResp.ack |=> bus.cyc && $stable(bus.adr));

endmodule

/* common/pipePkg.sv */
`include "coreConsts.svh"

package pipePkg;

    typedef logic [`CORE_XLEN-1:0]      word_t;
    typedef logic [`CORE_XLEN-1:0]      addr_t;
    typedef logic [`CORE_REG_IDX_W-1:0] regIdx_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                   regWrite;
        rvIsaPkg::resultSrc_e   resultSrc;
        rvIsaPkg::jumpKind_e    jump;
        rvIsaPkg::branchCond_e  branch;
        rvIsaPkg::aluOp_e       aluOp;
        logic                   aluSrcImm;  // operand b is the immediate.
    } ctrlFields_t;

    typedef struct packed {
        logic        valid;
        ctrlFields_t ctrl;
        word_t       rs1Val;
        word_t       rs2Val;
        addr_t       pc;
        regIdx_t     rd;
        word_t       imm;
        addr_t       pcPlus4;
    } decodeBundle_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
    } fetchPacket_t;

    typedef struct packed {
        addr_t   pc;
        regIdx_t rd;
        word_t   value;
    } retireRec_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone classic, read only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic  cyc;
        logic  stb;
        addr_t adr;
    } wbMaster_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wbSlave_t;

endpackage

/* common/rvIsaPkg.sv */
package rvIsaPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes of the supported RV32I subset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB                            // forwards operand b, used by lui.
    } aluOp_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branchCond_e;

    typedef enum logic [1:0] {
        JUMP_NONE, JUMP_JAL, JUMP_JALR
    } jumpKind_e;

    typedef enum logic [1:0] {
        RES_ALU, RES_PCPLUS4
    } resultSrc_e;

endpackage

/* common/coreConsts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core dimensions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CORE_XLEN       32              // data and address width.
`define CORE_REG_IDX_W  5               // bits needed to name one register.
`define CORE_NUM_REGS   32              // x0 is included in the count.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define CORE_RESET_PC   32'h0000_0000   // first fetch address after reset.

`endif
